/* sysCtrl_macros.svh */
`ifndef SYSCTRL_MACROS_SVH
`define SYSCTRL_MACROS_SVH

// Refresh phase counter
`define SC_REF_PERIOD     10 // Phases per refresh period
`define SC_REF_REQ_FIRST  3  // First phase with refReq high
`define SC_REF_URG_FIRST  7  // First phase with refUrgent high

// Long timer
`define SC_LONG_LEN       8192 // Refresh periods per long tick

// APB register map
`define SC_ADDR_CTRL      4'h0 // Clock and ROM enables
`define SC_ADDR_STATUS    4'h1 // Sequencer status, read only
`define SC_ADDR_CMD       4'h2 // Command strobes, write only

// CTRL after reset
`define SC_CTRL_RESET     3'b111 // Both oscillators and fast ROM on

// CMD bit positions
`define SC_CMD_RESTART    0 // Restart the power-up sequence

`endif

/* sysCtrlPkg.sv */
`default_nettype none

package sysCtrlPkg;

	typedef logic [3:0] regAddrT; // APB register address
	typedef logic [7:0] regDataT; // APB data word
	typedef logic [3:0] refPhaseT; // Refresh phase within a period

	// Power-up sequencer states
	typedef enum logic [1:0] {
		stHoldBus  = 2'd0, // Host in reset and bus tristated
		stNmiCheck = 2'd1, // Sample the NMI button for a bus veto
		stSettle   = 2'd2, // One more long period before release
		stRun      = 2'd3 // Card running
	} seqStateT;

	// APB request from the host bridge
	typedef struct packed {
		logic    sel; // PSEL
		logic    enable; // PENABLE
		logic    write; // PWRITE
		regAddrT addr; // PADDR
		regDataT wdata; // PWDATA
	} apbReqT;

	// APB response, PREADY is always high
	typedef struct packed {
		regDataT rdata; // PRDATA
		logic    slverr; // PSLVERR
	} apbRspT;

	// Sequencer state as seen by the register block
	typedef struct packed {
		seqStateT state;
		logic     busReqN; // PDS bus request, low requests the bus
		logic     sysResN; // Host reset, low holds reset
		logic     addrOe; // Address and control output enable
	} seqStatusT;

	// Oscillator and ROM enables
	typedef struct packed {
		logic osc20En; // 20 MHz oscillator
		logic osc25En; // 25 MHz oscillator
		logic fastRomEn; // Fast ROM access
	} clkCfgT;

endpackage

`default_nettype wire

/* sysTimer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sysCtrl_macros.svh"

module sysTimer import sysCtrlPkg::*; #(
	parameter int LongLen = `SC_LONG_LEN // Refresh periods per long tick
) (
	input  logic E,
	input  logic rstN,
	output logic refReq,
	output logic refUrgent,
	output logic longTick
);

	localparam int LongW = (LongLen > 1) ? $clog2(LongLen) : 1;

	// Phase boundaries, outputs are registered so each is set one phase early
	localparam refPhaseT LastPhase = refPhaseT'(`SC_REF_PERIOD - 1);
	localparam refPhaseT PreLast   = refPhaseT'(`SC_REF_PERIOD - 2);
	localparam refPhaseT ReqSet    = refPhaseT'(`SC_REF_REQ_FIRST - 1);
	localparam refPhaseT UrgSet    = refPhaseT'(`SC_REF_URG_FIRST - 1);

	localparam logic [LongW-1:0] LongLast = LongW'(LongLen - 1);

	refPhaseT         phase; // Free-running refresh phase
	logic [LongW-1:0] longCnt; // Completed refresh periods
	logic             periodEnd; // Last phase of the period
	logic             longWrap; // Current period is the last of the long interval

	assign periodEnd = (phase == LastPhase);
	assign longWrap  = (longCnt == LongLast);

	// Refresh phase counter
	always_ff @(posedge E) begin
		if (!rstN) begin
			phase <= '0; // Phase 0 in the first cycle after reset
		end else if (periodEnd) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// Refresh requests, high while the next phase is inside the window
	always_ff @(posedge E) begin
		if (!rstN) begin
			refReq    <= 1'b0;
			refUrgent <= 1'b0;
		end else begin
			refReq    <= (phase >= ReqSet) && !periodEnd; // Phases 3 to 9
			refUrgent <= (phase >= UrgSet) && !periodEnd; // Phases 7 to 9
		end
	end

	// Long timer, advances once per period
	always_ff @(posedge E) begin
		if (!rstN) begin
			longCnt <= '0;
		end else if (periodEnd) begin
			longCnt <= longWrap ? '0 : longCnt + 1'b1;
		end
	end

	// Tick lands in phase 9 of the wrapping period
	always_ff @(posedge E) begin
		if (!rstN) begin
			longTick <= 1'b0;
		end else begin
			longTick <= (phase == PreLast) && longWrap;
		end
	end

	// Urgent request only ever escalates a pending request
	urgentNeedsReq: assert property (@(posedge E) disable iff (!rstN)
		$rose(refUrgent) |-> refReq && $past(refReq))
		else $error("refUrgent rose without refReq");

endmodule

`default_nettype wire

/* startupSeq.sv */
`timescale 1ns/1ps
`default_nettype none

module startupSeq import sysCtrlPkg::*; (
	input  logic      E,
	input  logic      rstN,
	input  logic      longTick, // One pulse per long interval
	input  logic      nmiN, // NMI button, asynchronous and active low
	input  logic      restart, // One-cycle restart from the register block
	output seqStatusT status,
	output logic      sysResN,
	output logic      busReqN,
	output logic      addrOe
);

	logic     nmiMeta; // First synchronizer stage
	logic     nmiSync; // Button pressed, active high
	seqStateT state;
	seqStateT stateNext;

	// Two-flop synchronizer, pressed shows up two cycles later
	always_ff @(posedge E) begin
		if (!rstN) begin
			nmiMeta <= 1'b0;
			nmiSync <= 1'b0;
		end else begin
			nmiMeta <= !nmiN;
			nmiSync <= nmiMeta;
		end
	end

	// Next state, steps only on longTick
	always_comb begin
		stateNext = state;
		if (restart) begin
			stateNext = stHoldBus; // Back to the start, timers keep running
		end else if (longTick) begin
			unique case (state)
				stHoldBus:  stateNext = stNmiCheck;
				stNmiCheck: stateNext = nmiSync ? stNmiCheck : stSettle; // Wait for release
				stSettle:   stateNext = stRun;
				stRun:      stateNext = stRun; // Stays until restart
				default:    stateNext = stHoldBus;
			endcase
		end
	end

	always_ff @(posedge E) begin
		if (!rstN) begin
			state <= stHoldBus;
		end else begin
			state <= stateNext;
		end
	end

	// Bus request veto, sticky once the button is seen
	always_ff @(posedge E) begin
		if (!rstN || restart) begin
			busReqN <= 1'b0; // Default requests the bus
		end else if (state == stNmiCheck && nmiSync) begin
			busReqN <= 1'b1;
		end
	end

	// Host reset release on the first tick in stRun
	always_ff @(posedge E) begin
		if (!rstN || restart) begin
			sysResN <= 1'b0;
		end else if (state == stRun && longTick) begin
			sysResN <= 1'b1;
		end
	end

	// Address drivers follow the next state so they track stRun exactly
	always_ff @(posedge E) begin
		if (!rstN || restart) begin
			addrOe <= 1'b0; // Tristate PDS address and control
		end else begin
			addrOe <= (stateNext == stRun) && !busReqN;
		end
	end

	assign status = '{state: state, busReqN: busReqN, sysResN: sysResN, addrOe: addrOe};

	// Drivers only in stRun, and there only when the bus is ours
	addrOeOnlyInRun: assert property (@(posedge E) disable iff (!rstN)
		addrOe == (state == stRun && !busReqN))
		else $error("addrOe outside stRun or not matching busReqN");

	// Veto is only cleared by reset or restart
	busReqNSticky: assert property (@(posedge E) disable iff (!rstN)
		$fell(busReqN) |-> $past(restart) || !$past(rstN))
		else $error("busReqN fell without reset or restart");

endmodule

`default_nettype wire

/* cfgRegs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sysCtrl_macros.svh"

module cfgRegs import sysCtrlPkg::*; (
	input  logic      E,
	input  logic      rstN,
	input  apbReqT    apbReq,
	output apbRspT    apbRsp,
	input  seqStatusT status, // Live sequencer state
	output clkCfgT    clkCfg, // CTRL register contents
	output logic      restart // Pulse one cycle after the CMD write
);

	logic    access; // Access phase of a transfer
	logic    wrAccess;
	logic    rdAccess;
	logic    hitCtrl;
	logic    hitStatus;
	logic    hitCmd;
	logic    mapped; // Address is one of the three registers
	logic    slvErr;
	logic    ctrlWe;
	regDataT rdData;

	assign access   = apbReq.sel && apbReq.enable; // Completes this cycle
	assign wrAccess = access && apbReq.write;
	assign rdAccess = access && !apbReq.write;

	// Address decode
	assign hitCtrl   = (apbReq.addr == `SC_ADDR_CTRL);
	assign hitStatus = (apbReq.addr == `SC_ADDR_STATUS);
	assign hitCmd    = (apbReq.addr == `SC_ADDR_CMD);
	assign mapped    = hitCtrl || hitStatus || hitCmd;

	// Unmapped address or a write to the read-only STATUS
	assign slvErr = access && (!mapped || (apbReq.write && hitStatus));

	assign ctrlWe = wrAccess && hitCtrl;

	// CTRL register
	always_ff @(posedge E) begin
		if (!rstN) begin
			clkCfg <= `SC_CTRL_RESET; // All enables on
		end else if (ctrlWe) begin
			clkCfg <= apbReq.wdata[$bits(clkCfgT)-1:0]; // Upper bits ignored
		end
	end

	// CMD strobe, one cycle after the access
	always_ff @(posedge E) begin
		if (!rstN) begin
			restart <= 1'b0;
		end else begin
			restart <= wrAccess && hitCmd && apbReq.wdata[`SC_CMD_RESTART];
		end
	end

	// Read mux, combinational in the access cycle
	always_comb begin
		rdData = '0;
		if (rdAccess) begin
			if (hitCtrl) begin
				rdData = regDataT'(clkCfg); // Bits 2 to 0
			end else if (hitStatus) begin
				rdData = regDataT'(status); // Bits 4 to 0
			end
			// CMD and unmapped read zero
		end
	end

	assign apbRsp = '{rdata: rdData, slverr: slvErr};

	// Every access phase follows a setup phase on the same select
	apbSetupFirst: assert property (@(posedge E) disable iff (!rstN)
		apbReq.enable |-> apbReq.sel && $past(apbReq.sel && !apbReq.enable))
		else $error("APB enable without a preceding setup phase");

endmodule

`default_nettype wire

/* sysCtrlTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sysCtrl_macros.svh"

module sysCtrlTop import sysCtrlPkg::*; #(
	parameter int LongLen = `SC_LONG_LEN // Shorten for simulation
) (
	input  logic   E, // Card clock, rising edge only
	input  logic   rstN, // Synchronous, active low
	input  logic   nmiN, // NMI button
	input  apbReqT apbReq,
	output apbRspT apbRsp,
	output logic   refReq, // DRAM refresh wanted
	output logic   refUrgent, // DRAM refresh overdue
	output logic   sysResN, // Host reset
	output logic   busReqN, // PDS bus request
	output logic   addrOe, // PDS address output enable
	output clkCfgT clkCfg // Oscillator and ROM enables
);

	logic      longTick; // Timer to sequencer
	logic      restart; // Register block to sequencer
	seqStatusT status; // Sequencer to register block

	// Refresh phase and long interval
	sysTimer #(
		.LongLen   (LongLen)
	) timer (
		.E         (E),
		.rstN      (rstN),
		.refReq    (refReq),
		.refUrgent (refUrgent),
		.longTick  (longTick)
	);

	// Power-up sequence
	startupSeq seq (
		.E        (E),
		.rstN     (rstN),
		.longTick (longTick),
		.nmiN     (nmiN),
		.restart  (restart),
		.status   (status),
		.sysResN  (sysResN),
		.busReqN  (busReqN),
		.addrOe   (addrOe)
	);

	// APB registers
	cfgRegs regs (
		.E       (E),
		.rstN    (rstN),
		.apbReq  (apbReq),
		.apbRsp  (apbRsp),
		.status  (status),
		.clkCfg  (clkCfg),
		.restart (restart)
	);

endmodule

`default_nettype wire

/* sysCtrlTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "sysCtrl_macros.svh"

module sysCtrlTb import sysCtrlPkg::*; ();

	localparam int          LongLen  = 8; // Short long interval for simulation
	localparam int          TickCyc  = `SC_REF_PERIOD * LongLen; // Cycles per long tick
	localparam logic [15:0] LfsrSeed = 16'd60890;

	typedef enum logic [1:0] {kWrite, kRead, kWait, kNmi} stepKindT;

	typedef struct packed {
		stepKindT kind;
		regAddrT  addr;
		regDataT  data; // Write data, tick count or NMI level
		regDataT  expRd;
		logic     expErr;
	} stepT;

	logic   E;
	logic   rstN;
	logic   nmiN;
	apbReqT apbReq;
	apbRspT apbRsp;
	logic   refReq;
	logic   refUrgent;
	logic   sysResN;
	logic   busReqN;
	logic   addrOe;
	clkCfgT clkCfg;

	stepT        steps[$]; // Test table
	logic [15:0] lfsrState;
	int          cyc = 0; // Cycles since reset release
	int          cycles = 0; // Watchdog count
	int          cycleLimit = 0;
	logic        refCheckEn;
	int          refPhase; // Predicted refresh phase
	logic        expReq;
	logic        expUrg;

	sysCtrlTop #(
		.LongLen   (LongLen)
	) uut (
		.E         (E),
		.rstN      (rstN),
		.nmiN      (nmiN),
		.apbReq    (apbReq),
		.apbRsp    (apbRsp),
		.refReq    (refReq),
		.refUrgent (refUrgent),
		.sysResN   (sysResN),
		.busReqN   (busReqN),
		.addrOe    (addrOe),
		.clkCfg    (clkCfg)
	);

	initial begin
		E = 1'b0;
		forever #20 E = ~E; // 40 ns period
	end

	task automatic failRun();
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped at the first error");
	endtask

	// Refresh model, phase 0 in the first cycle after reset
	always @(posedge E) begin
		if (!rstN) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	assign refPhase = cyc % `SC_REF_PERIOD;
	assign expReq   = (refPhase >= 3); // Phases 3 to 9
	assign expUrg   = (refPhase >= 7); // Phases 7 to 9

	always @(negedge E) begin
		if (refCheckEn) begin
			assert (refReq === expReq) else begin
				$display("ERROR: refReq expected 0x%0h got 0x%0h in phase %0d",
					expReq, refReq, refPhase);
				failRun();
			end
			assert (refUrgent === expUrg) else begin
				$display("ERROR: refUrgent expected 0x%0h got 0x%0h in phase %0d",
					expUrg, refUrgent, refPhase);
				failRun();
			end
		end
	end

	// Watchdog
	always @(posedge E) begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("TIMEOUT: the run did not finish within %0d cycles", cycleLimit);
			failRun();
		end
	end

	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic drawByte(output regDataT b);
		b = '0;
		repeat (8) begin
			lfsrState = lfsrNext(lfsrState); // One step per bit
			b = {b[6:0], lfsrState[0]};
		end
	endtask

	// STATUS layout: state in 4:3, busReqN, sysResN, addrOe
	function automatic regDataT statusExp(input seqStateT st, input logic bus,
		input logic res, input logic oe);
		return {3'b000, st, bus, res, oe};
	endfunction

	task automatic addStep(input stepKindT kind, input regAddrT addr, input regDataT data,
		input regDataT expRd, input logic expErr);
		steps.push_back(stepT'{kind, addr, data, expRd, expErr});
	endtask

	task automatic addRead(input regAddrT addr, input regDataT expRd, input logic expErr);
		addStep(kRead, addr, 8'h00, expRd, expErr);
	endtask

	task automatic addWrite(input regAddrT addr, input regDataT data, input logic expErr);
		addStep(kWrite, addr, data, 8'h00, expErr);
	endtask

	task automatic addWaitRead(input int n, input regDataT expSt);
		addStep(kWait, 4'h0, regDataT'(n), 8'h00, 1'b0);
		addRead(`SC_ADDR_STATUS, expSt, 1'b0); // Sample right after the tick
	endtask

	task automatic buildTable();
		regDataT rnd;
		regDataT ctrlExp;
		ctrlExp = 8'h07; // All enables on after reset
		addRead(`SC_ADDR_CTRL, ctrlExp, 1'b0);
		addRead(`SC_ADDR_STATUS, statusExp(stHoldBus, 0, 0, 0), 1'b0);
		addWaitRead(1, statusExp(stNmiCheck, 0, 0, 0)); // Normal power-up
		addWaitRead(1, statusExp(stSettle, 0, 0, 0));
		addWaitRead(1, statusExp(stRun, 0, 0, 1));
		addWaitRead(1, statusExp(stRun, 0, 1, 1)); // Host out of reset
		addWaitRead(1, statusExp(stRun, 0, 1, 1));
		addStep(kNmi, 4'h0, 8'h00, 8'h00, 1'b0); // Press NMI
		addWrite(`SC_ADDR_CMD, 8'h01, 1'b0); // Restart
		addRead(`SC_ADDR_STATUS, statusExp(stHoldBus, 0, 0, 0), 1'b0);
		addWaitRead(1, statusExp(stNmiCheck, 1, 0, 0)); // Veto latched
		addWaitRead(1, statusExp(stNmiCheck, 1, 0, 0)); // Held while pressed
		addStep(kNmi, 4'h0, 8'h01, 8'h00, 1'b0); // Release NMI
		addWaitRead(1, statusExp(stSettle, 1, 0, 0));
		addWaitRead(1, statusExp(stRun, 1, 0, 0)); // Bus not taken
		addWaitRead(1, statusExp(stRun, 1, 1, 0));
		repeat (4) begin
			drawByte(rnd);
			addWrite(`SC_ADDR_CTRL, rnd, 1'b0);
			ctrlExp = rnd & 8'h07; // Only bits 2 to 0 kept
			addRead(`SC_ADDR_CTRL, ctrlExp, 1'b0);
		end
		addWrite(4'h3, 8'hFF, 1'b1); // Unmapped addresses
		addRead(4'h3, 8'h00, 1'b1);
		addWrite(4'hF, 8'h00, 1'b1);
		addRead(4'h8, 8'h00, 1'b1);
		addWrite(`SC_ADDR_STATUS, 8'h00, 1'b1); // Read-only
		addRead(`SC_ADDR_CTRL, ctrlExp, 1'b0);
		addWrite(`SC_ADDR_CMD, 8'h00, 1'b0); // No restart
		addRead(`SC_ADDR_CMD, 8'h00, 1'b0); // Write-only reads zero
		addRead(`SC_ADDR_STATUS, statusExp(stRun, 1, 1, 0), 1'b0); // Still running
		foreach (steps[i]) begin
			if (steps[i].kind == kWait) begin
				cycleLimit += steps[i].data * TickCyc;
			end else if (steps[i].kind != kNmi) begin
				cycleLimit += 4;
			end
		end
		cycleLimit += 100;
	endtask

	task automatic nextCycle();
		@(posedge E);
		#2; // Drive after the edge
	endtask

	// Wait until the cycle after each of n long ticks
	task automatic waitTicks(input int n);
		repeat (n) begin
			nextCycle();
			while ((cyc % TickCyc) != 0) begin
				nextCycle();
			end
		end
	endtask

	task automatic runApb(input stepT s);
		apbReq = '{sel: 1'b1, enable: 1'b0, write: (s.kind == kWrite),
			addr: s.addr, wdata: s.data}; // Setup
		nextCycle();
		apbReq.enable = 1'b1; // Access
		@(negedge E);
		assert (apbRsp.slverr === s.expErr) else begin
			$display("ERROR: apbRsp.slverr at addr 0x%0h expected 0x%0h got 0x%0h",
				s.addr, s.expErr, apbRsp.slverr);
			failRun();
		end
		if (s.kind == kRead) begin
			assert (apbRsp.rdata === s.expRd) else begin
				$display("ERROR: apbRsp.rdata at addr 0x%0h expected 0x%02h got 0x%02h",
					s.addr, s.expRd, apbRsp.rdata);
				failRun();
			end
			if (s.addr == `SC_ADDR_CTRL) begin
				assert (clkCfg === s.expRd[2:0]) else begin
					$display("ERROR: clkCfg expected 0x%0h got 0x%0h", s.expRd[2:0], clkCfg);
					failRun();
				end
			end
			if (s.addr == `SC_ADDR_STATUS) begin
				assert ({busReqN, sysResN, addrOe} === s.expRd[2:0]) else begin
					$display("ERROR: {busReqN,sysResN,addrOe} expected 0x%0h got 0x%0h",
						s.expRd[2:0], {busReqN, sysResN, addrOe});
					failRun();
				end
			end
		end
		nextCycle();
		apbReq = '0; // Idle
	endtask

	initial begin
		rstN       = 1'b0;
		nmiN       = 1'b1; // Button released
		apbReq     = '0;
		refCheckEn = 1'b0;
		lfsrState  = LfsrSeed;
		buildTable();
		repeat (4) begin
			nextCycle();
		end
		rstN       = 1'b1;
		refCheckEn = 1'b1;
		foreach (steps[i]) begin
			case (steps[i].kind)
				kWait:   waitTicks(steps[i].data);
				kNmi:    nmiN = steps[i].data[0];
				default: runApb(steps[i]);
			endcase
		end
		nextCycle();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
sysCtrlPkg.sv
sysTimer.sv
startupSeq.sv
cfgRegs.sv
sysCtrlTop.sv
sysCtrlTb.sv

/* Bender.yml */
package:
  name: sysctrl

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - sysCtrlPkg.sv
      - sysTimer.sv
      - startupSeq.sv
      - cfgRegs.sv
      - sysCtrlTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - sysCtrlTb.sv
